// ==== rtl/ex_cfg.svh ====
// width settings for the execute stage, included by every file that sizes a datapath
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// integer register and datapath width
`define EX_XLEN 64

// architectural register index width
`define EX_RADDR_W 5

// opaque memory/writeback control carried through the stage
`define EX_CTRL_W 16

`endif

// ==== rtl/ex_pkg.sv ====
// operation encodings shared by the execute stage RTL and its testbench, import where needed
package ex_pkg;

  // alu operation select, set by decode per instruction
  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    // result is op2 unchanged, for lui
    alu_pass2 = 4'd10
  } alu_op_e;

  // control-flow kind of the instruction
  typedef enum logic [3:0] {
    bj_none = 4'd0,
    bj_beq  = 4'd1,
    bj_bne  = 4'd2,
    bj_blt  = 4'd3,
    bj_bge  = 4'd4,
    bj_bltu = 4'd5,
    bj_bgeu = 4'd6,
    bj_jal  = 4'd7,
    bj_jalr = 4'd8
  } bj_op_e;

  // true for any branch or jump
  function automatic logic is_ctrl_flow(bj_op_e op);
    logic cf;
    cf = (op != bj_none);
    return cf;
  endfunction

endpackage

// ==== rtl/ex_forward.sv ====
// operand bypass for the execute stage, picks the newest rs1/rs2 and flags load-use hazards
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_forward (
  input  logic [`EX_RADDR_W-1:0] rs1_addr,
  input  logic [`EX_RADDR_W-1:0] rs2_addr,
  input  logic [`EX_XLEN-1:0]    rs1_data,
  input  logic [`EX_XLEN-1:0]    rs2_data,
  input  logic                   use_rs1,
  input  logic                   use_rs2,
  input  logic                   mfw_ena,
  input  logic                   mfw_is_load,
  input  logic [`EX_RADDR_W-1:0] mfw_addr,
  input  logic [`EX_XLEN-1:0]    mfw_data,
  input  logic                   wfw_ena,
  input  logic [`EX_RADDR_W-1:0] wfw_addr,
  input  logic [`EX_XLEN-1:0]    wfw_data,
  output logic [`EX_XLEN-1:0]    rs1_fwd,
  output logic [`EX_XLEN-1:0]    rs2_fwd,
  output logic                   hazard
);

  logic mem_hit1;
  logic mem_hit2;
  logic wb_hit1;
  logic wb_hit2;

  // x0 is hardwired, never take a bypass for it
  function automatic logic fwd_hit(logic ena, logic [`EX_RADDR_W-1:0] fwd_addr,
                                   logic [`EX_RADDR_W-1:0] src_addr);
    logic hit;
    hit = ena && (fwd_addr != '0) && (fwd_addr == src_addr);
    return hit;
  endfunction

  assign mem_hit1 = fwd_hit(mfw_ena, mfw_addr, rs1_addr);
  assign mem_hit2 = fwd_hit(mfw_ena, mfw_addr, rs2_addr);
  assign wb_hit1  = fwd_hit(wfw_ena, wfw_addr, rs1_addr);
  assign wb_hit2  = fwd_hit(wfw_ena, wfw_addr, rs2_addr);

  // memory stage is younger than writeback, so it wins
  assign rs1_fwd = mem_hit1 ? mfw_data : (wb_hit1 ? wfw_data : rs1_data);
  assign rs2_fwd = mem_hit2 ? mfw_data : (wb_hit2 ? wfw_data : rs2_data);

  // load data not back yet, must wait a cycle
  assign hazard = mfw_is_load && ((use_rs1 && mem_hit1) || (use_rs2 && mem_hit2));

endmodule

// ==== rtl/ex_alu.sv ====
// integer ALU of the execute stage with RV64 word forms and compare flags for the branch unit
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_alu (
  input  logic [`EX_XLEN-1:0] op1,
  input  logic [`EX_XLEN-1:0] op2,
  input  ex_pkg::alu_op_e     alu_op,
  input  logic                is_word,
  output logic [`EX_XLEN-1:0] result,
  output logic                eq,
  output logic                lt,
  output logic                ltu
);

  import ex_pkg::*;

  logic [5:0]          shamt;
  logic [31:0]         srl_w;
  logic signed [31:0]  sra_w;
  logic [`EX_XLEN-1:0] srl_d;
  logic [`EX_XLEN-1:0] sra_d;
  logic [`EX_XLEN-1:0] raw;

  // flags always on the full operands
  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  // word shifts only see five amount bits
  assign shamt = is_word ? {1'b0, op2[4:0]} : op2[5:0];

  // right shifts in word mode work on the low half only
  assign srl_w = op1[31:0] >> shamt[4:0];
  assign sra_w = $signed(op1[31:0]) >>> shamt[4:0];
  assign srl_d = op1 >> shamt;
  assign sra_d = $signed(op1) >>> shamt;

  always_comb begin
    case (alu_op)
      alu_add: begin
        raw = op1 + op2;
      end
      alu_sub: begin
        raw = op1 - op2;
      end
      alu_sll: begin
        raw = op1 << shamt;
      end
      alu_slt: begin
        raw = {{(`EX_XLEN-1){1'b0}}, lt};
      end
      alu_sltu: begin
        raw = {{(`EX_XLEN-1){1'b0}}, ltu};
      end
      alu_xor: begin
        raw = op1 ^ op2;
      end
      alu_srl: begin
        raw = is_word ? {32'b0, srl_w} : srl_d;
      end
      alu_sra: begin
        raw = is_word ? {{32{sra_w[31]}}, sra_w} : sra_d;
      end
      alu_or: begin
        raw = op1 | op2;
      end
      alu_and: begin
        raw = op1 & op2;
      end
      alu_pass2: begin
        raw = op2;
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // word results sign-extend from bit 31
  assign result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== rtl/ex_branch.sv ====
// branch resolution for the execute stage, turns ALU compare flags into a redirect
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_branch (
  input  logic                valid,
  input  ex_pkg::bj_op_e      bj_op,
  input  logic                eq,
  input  logic                lt,
  input  logic                ltu,
  input  logic [`EX_XLEN-1:0] pc,
  input  logic [`EX_XLEN-1:0] imm,
  input  logic [`EX_XLEN-1:0] rs1,
  output logic                taken,
  output logic [`EX_XLEN-1:0] target
);

  import ex_pkg::*;

  logic                cond;
  logic [`EX_XLEN-1:0] jalr_sum;

  always_comb begin
    case (bj_op)
      bj_beq:  cond = eq;
      bj_bne:  cond = !eq;
      bj_blt:  cond = lt;
      bj_bge:  cond = !lt;
      bj_bltu: cond = ltu;
      bj_bgeu: cond = !ltu;
      // unconditional jumps
      bj_jal:  cond = 1'b1;
      bj_jalr: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign taken = valid && cond;

  // jalr drops bit 0 of the computed address
  assign jalr_sum = rs1 + imm;
  assign target   = (bj_op == bj_jalr) ? {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc + imm;

endmodule

// ==== rtl/ex_stage.sv ====
// execute stage top, holds one decoded instruction and hands its result to the memory stage
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst,
  // from decode
  input  logic                   id_valid,
  output logic                   ex_allowin,
  input  logic [`EX_XLEN-1:0]    id_pc,
  input  logic [`EX_RADDR_W-1:0] id_rs1_addr,
  input  logic [`EX_RADDR_W-1:0] id_rs2_addr,
  input  logic [`EX_XLEN-1:0]    id_rs1_data,
  input  logic [`EX_XLEN-1:0]    id_rs2_data,
  input  logic                   id_use_rs1,
  input  logic                   id_use_rs2,
  input  logic [`EX_XLEN-1:0]    id_op1,
  input  logic [`EX_XLEN-1:0]    id_op2,
  input  ex_pkg::alu_op_e        id_alu_op,
  input  logic                   id_is_word,
  input  ex_pkg::bj_op_e         id_bj_op,
  input  logic [`EX_XLEN-1:0]    id_imm,
  input  logic [`EX_CTRL_W-1:0]  id_ctrl,
  // bypass sources
  input  logic                   mfw_ena,
  input  logic [`EX_RADDR_W-1:0] mfw_addr,
  input  logic [`EX_XLEN-1:0]    mfw_data,
  input  logic                   mfw_is_load,
  input  logic                   wfw_ena,
  input  logic [`EX_RADDR_W-1:0] wfw_addr,
  input  logic [`EX_XLEN-1:0]    wfw_data,
  // to memory
  input  logic                   mem_allowin,
  output logic                   mem_valid,
  output logic [`EX_XLEN-1:0]    mem_pc,
  output logic [`EX_XLEN-1:0]    mem_result,
  output logic [`EX_XLEN-1:0]    mem_store_data,
  output logic [`EX_CTRL_W-1:0]  mem_ctrl,
  // redirect to fetch
  output logic                   bj_taken,
  output logic [`EX_XLEN-1:0]    bj_pc,
  output logic                   bj_stall
);

  import ex_pkg::*;

  logic                   ex_valid;
  logic                   ex_ready_go;
  logic                   hazard;

  // held instruction
  logic [`EX_XLEN-1:0]    ex_pc;
  logic [`EX_RADDR_W-1:0] ex_rs1_addr;
  logic [`EX_RADDR_W-1:0] ex_rs2_addr;
  logic [`EX_XLEN-1:0]    ex_rs1_data;
  logic [`EX_XLEN-1:0]    ex_rs2_data;
  logic                   ex_use_rs1;
  logic                   ex_use_rs2;
  logic [`EX_XLEN-1:0]    ex_op1;
  logic [`EX_XLEN-1:0]    ex_op2;
  alu_op_e                ex_alu_op;
  logic                   ex_is_word;
  bj_op_e                 ex_bj_op;
  logic [`EX_XLEN-1:0]    ex_imm;
  logic [`EX_CTRL_W-1:0]  ex_ctrl;

  logic [`EX_XLEN-1:0]    rs1_fwd;
  logic [`EX_XLEN-1:0]    rs2_fwd;
  logic [`EX_XLEN-1:0]    sel_op1;
  logic [`EX_XLEN-1:0]    sel_op2;
  logic [`EX_XLEN-1:0]    alu_op1;
  logic [`EX_XLEN-1:0]    alu_op2;
  logic                   cmp_eq;
  logic                   cmp_lt;
  logic                   cmp_ltu;

  // handshake, stage can drain and refill in the same cycle
  assign ex_ready_go = !hazard;
  assign ex_allowin  = !ex_valid || (ex_ready_go && mem_allowin);
  assign mem_valid   = ex_valid && ex_ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid && ex_allowin) begin
      ex_pc       <= id_pc;
      ex_rs1_addr <= id_rs1_addr;
      ex_rs2_addr <= id_rs2_addr;
      ex_rs1_data <= id_rs1_data;
      ex_rs2_data <= id_rs2_data;
      ex_use_rs1  <= id_use_rs1;
      ex_use_rs2  <= id_use_rs2;
      ex_op1      <= id_op1;
      ex_op2      <= id_op2;
      ex_alu_op   <= id_alu_op;
      ex_is_word  <= id_is_word;
      ex_bj_op    <= id_bj_op;
      ex_imm      <= id_imm;
      ex_ctrl     <= id_ctrl;
    end
  end

  ex_forward u_forward (
    .rs1_addr    (ex_rs1_addr),
    .rs2_addr    (ex_rs2_addr),
    .rs1_data    (ex_rs1_data),
    .rs2_data    (ex_rs2_data),
    .use_rs1     (ex_use_rs1),
    .use_rs2     (ex_use_rs2),
    .mfw_ena     (mfw_ena),
    .mfw_is_load (mfw_is_load),
    .mfw_addr    (mfw_addr),
    .mfw_data    (mfw_data),
    .wfw_ena     (wfw_ena),
    .wfw_addr    (wfw_addr),
    .wfw_data    (wfw_data),
    .rs1_fwd     (rs1_fwd),
    .rs2_fwd     (rs2_fwd),
    .hazard      (hazard)
  );

  // register value when the instruction reads it, else decode's immediate/pc operand
  assign sel_op1 = ex_use_rs1 ? rs1_fwd : ex_op1;
  assign sel_op2 = ex_use_rs2 ? rs2_fwd : ex_op2;

  // word ops see only the low half
  assign alu_op1 = {sel_op1[`EX_XLEN-1:32] & {(`EX_XLEN-32){!ex_is_word}}, sel_op1[31:0]};
  assign alu_op2 = {sel_op2[`EX_XLEN-1:32] & {(`EX_XLEN-32){!ex_is_word}}, sel_op2[31:0]};

  ex_alu u_alu (
    .op1     (alu_op1),
    .op2     (alu_op2),
    .alu_op  (ex_alu_op),
    .is_word (ex_is_word),
    .result  (mem_result),
    .eq      (cmp_eq),
    .lt      (cmp_lt),
    .ltu     (cmp_ltu)
  );

  ex_branch u_branch (
    .valid  (ex_valid),
    .bj_op  (ex_bj_op),
    .eq     (cmp_eq),
    .lt     (cmp_lt),
    .ltu    (cmp_ltu),
    .pc     (ex_pc),
    .imm    (ex_imm),
    .rs1    (rs1_fwd),
    .taken  (bj_taken),
    .target (bj_pc)
  );

  assign mem_pc         = ex_pc;
  assign mem_store_data = rs2_fwd;
  assign mem_ctrl       = ex_ctrl;

  // fetch must not trust bj_taken/bj_pc while this is high
  assign bj_stall = ex_valid && is_ctrl_flow(ex_bj_op) && hazard;

endmodule

// ==== test/ex_stage_tb.sv ====
// random-stimulus testbench for the execute stage that files.f builds as the top module
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int NUM_ITEMS   = 400;
  localparam int ITEM_LIMIT  = 20000;
  localparam int DRAIN_LIMIT = 200;

  // one decoded instruction as the model sees it
  typedef struct packed {
    logic [`EX_XLEN-1:0]    pc;
    logic [`EX_RADDR_W-1:0] rs1_addr;
    logic [`EX_RADDR_W-1:0] rs2_addr;
    logic [`EX_XLEN-1:0]    rs1_data;
    logic [`EX_XLEN-1:0]    rs2_data;
    logic                   use_rs1;
    logic                   use_rs2;
    logic [`EX_XLEN-1:0]    op1;
    logic [`EX_XLEN-1:0]    op2;
    alu_op_e                alu_op;
    logic                   is_word;
    bj_op_e                 bj_op;
    logic [`EX_XLEN-1:0]    imm;
    logic [`EX_CTRL_W-1:0]  ctrl;
  } item_t;

  logic                   clk;
  logic                   rst;
  logic                   id_valid;
  logic                   ex_allowin;
  logic [`EX_XLEN-1:0]    id_pc;
  logic [`EX_RADDR_W-1:0] id_rs1_addr;
  logic [`EX_RADDR_W-1:0] id_rs2_addr;
  logic [`EX_XLEN-1:0]    id_rs1_data;
  logic [`EX_XLEN-1:0]    id_rs2_data;
  logic                   id_use_rs1;
  logic                   id_use_rs2;
  logic [`EX_XLEN-1:0]    id_op1;
  logic [`EX_XLEN-1:0]    id_op2;
  alu_op_e                id_alu_op;
  logic                   id_is_word;
  bj_op_e                 id_bj_op;
  logic [`EX_XLEN-1:0]    id_imm;
  logic [`EX_CTRL_W-1:0]  id_ctrl;
  logic                   mfw_ena;
  logic [`EX_RADDR_W-1:0] mfw_addr;
  logic [`EX_XLEN-1:0]    mfw_data;
  logic                   mfw_is_load;
  logic                   wfw_ena;
  logic [`EX_RADDR_W-1:0] wfw_addr;
  logic [`EX_XLEN-1:0]    wfw_data;
  logic                   mem_allowin;
  logic                   mem_valid;
  logic [`EX_XLEN-1:0]    mem_pc;
  logic [`EX_XLEN-1:0]    mem_result;
  logic [`EX_XLEN-1:0]    mem_store_data;
  logic [`EX_CTRL_W-1:0]  mem_ctrl;
  logic                   bj_taken;
  logic [`EX_XLEN-1:0]    bj_pc;
  logic                   bj_stall;

  integer seed;
  item_t  model_q[$];
  item_t  cur_item;
  int     sent;
  int     stall_cnt;
  int     taken_cnt;
  logic   exp_allowin;
  logic   exp_mem_valid;

  ex_stage dut (
    .clk            (clk),
    .rst            (rst),
    .id_valid       (id_valid),
    .ex_allowin     (ex_allowin),
    .id_pc          (id_pc),
    .id_rs1_addr    (id_rs1_addr),
    .id_rs2_addr    (id_rs2_addr),
    .id_rs1_data    (id_rs1_data),
    .id_rs2_data    (id_rs2_data),
    .id_use_rs1     (id_use_rs1),
    .id_use_rs2     (id_use_rs2),
    .id_op1         (id_op1),
    .id_op2         (id_op2),
    .id_alu_op      (id_alu_op),
    .id_is_word     (id_is_word),
    .id_bj_op       (id_bj_op),
    .id_imm         (id_imm),
    .id_ctrl        (id_ctrl),
    .mfw_ena        (mfw_ena),
    .mfw_addr       (mfw_addr),
    .mfw_data       (mfw_data),
    .mfw_is_load    (mfw_is_load),
    .wfw_ena        (wfw_ena),
    .wfw_addr       (wfw_addr),
    .wfw_data       (wfw_data),
    .mem_allowin    (mem_allowin),
    .mem_valid      (mem_valid),
    .mem_pc         (mem_pc),
    .mem_result     (mem_result),
    .mem_store_data (mem_store_data),
    .mem_ctrl       (mem_ctrl),
    .bj_taken       (bj_taken),
    .bj_pc          (bj_pc),
    .bj_stall       (bj_stall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, logic [`EX_XLEN-1:0] got, logic [`EX_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ctrl(string name, logic [`EX_CTRL_W-1:0] got,
                            logic [`EX_CTRL_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [`EX_XLEN-1:0] rand64();
    logic [`EX_XLEN-1:0] v;
    v = {rand32(), rand32()};
    return v;
  endfunction

  // newest value of a source with memory ahead of writeback and x0 never bypassed
  function automatic logic [`EX_XLEN-1:0] pick_source(logic [`EX_RADDR_W-1:0] addr,
                                                     logic [`EX_XLEN-1:0] data);
    logic [`EX_XLEN-1:0] v;
    v = data;
    if (addr != '0 && wfw_ena && wfw_addr == addr) begin
      v = wfw_data;
    end
    if (addr != '0 && mfw_ena && mfw_addr == addr) begin
      v = mfw_data;
    end
    return v;
  endfunction

  // operands arrive already masked for word mode
  function automatic logic [`EX_XLEN-1:0] model_alu(alu_op_e op, logic [`EX_XLEN-1:0] a,
                                                   logic [`EX_XLEN-1:0] b, logic w);
    logic [`EX_XLEN-1:0] r;
    logic signed [31:0]  s_lo;
    logic signed [`EX_XLEN-1:0] s_full;
    s_lo   = $signed(a[31:0]) >>> b[4:0];
    s_full = $signed(a) >>> b[5:0];
    case (op)
      alu_add:   r = a + b;
      alu_sub:   r = a - b;
      alu_sll:   r = w ? (a << b[4:0]) : (a << b[5:0]);
      alu_slt:   r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_sltu:  r = (a < b) ? 64'd1 : 64'd0;
      alu_xor:   r = a ^ b;
      alu_srl:   r = w ? {32'd0, a[31:0] >> b[4:0]} : (a >> b[5:0]);
      alu_sra:   r = w ? {32'd0, s_lo} : s_full;
      alu_or:    r = a | b;
      alu_and:   r = a & b;
      alu_pass2: r = b;
      default:   r = '0;
    endcase
    if (w) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  function automatic logic branch_cond(bj_op_e op, logic [`EX_XLEN-1:0] a,
                                       logic [`EX_XLEN-1:0] b);
    logic c;
    case (op)
      bj_beq:  c = (a == b);
      bj_bne:  c = (a != b);
      bj_blt:  c = ($signed(a) < $signed(b));
      bj_bge:  c = !($signed(a) < $signed(b));
      bj_bltu: c = (a < b);
      bj_bgeu: c = !(a < b);
      bj_jal:  c = 1'b1;
      bj_jalr: c = 1'b1;
      default: c = 1'b0;
    endcase
    return c;
  endfunction

  // new bypass state, back-pressure and a fresh decode item every cycle
  task automatic drive_inputs(logic allow_new);
    logic [31:0] r;
    r = rand32();
    mfw_ena     = r[0];
    mfw_is_load = r[1];
    mfw_addr    = {3'b000, r[3:2]};
    wfw_ena     = r[4];
    wfw_addr    = {3'b000, r[6:5]};
    mem_allowin = (r[9:7] != 3'd0);
    id_valid    = allow_new && (r[11:10] != 2'd0);
    mfw_data    = rand64();
    wfw_data    = rand64();
    r = rand32();
    cur_item.pc       = rand64();
    cur_item.rs1_addr = {3'b000, r[1:0]};
    cur_item.rs2_addr = {3'b000, r[3:2]};
    cur_item.rs1_data = rand64();
    cur_item.rs2_data = r[12] ? cur_item.rs1_data : rand64();
    cur_item.use_rs1  = r[4];
    cur_item.use_rs2  = r[5];
    cur_item.op1      = rand64();
    cur_item.op2      = r[12] ? cur_item.op1 : rand64();
    cur_item.alu_op   = alu_op_e'(r[9:6] % 4'd11);
    cur_item.is_word  = r[10];
    cur_item.bj_op    = r[11] ? bj_none : bj_op_e'(4'd1 + (r[16:13] % 4'd8));
    cur_item.imm      = rand64();
    cur_item.ctrl     = r[31:16];
    id_pc       = cur_item.pc;
    id_rs1_addr = cur_item.rs1_addr;
    id_rs2_addr = cur_item.rs2_addr;
    id_rs1_data = cur_item.rs1_data;
    id_rs2_data = cur_item.rs2_data;
    id_use_rs1  = cur_item.use_rs1;
    id_use_rs2  = cur_item.use_rs2;
    id_op1      = cur_item.op1;
    id_op2      = cur_item.op2;
    id_alu_op   = cur_item.alu_op;
    id_is_word  = cur_item.is_word;
    id_bj_op    = cur_item.bj_op;
    id_imm      = cur_item.imm;
    id_ctrl     = cur_item.ctrl;
  endtask

  // compare every output against the head of the model queue
  task automatic verify_cycle();
    item_t               it;
    logic                held;
    logic                hz;
    logic                cond;
    logic [`EX_XLEN-1:0] fwd1;
    logic [`EX_XLEN-1:0] fwd2;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] exp_tgt;
    held = (model_q.size() != 0);
    hz   = 1'b0;
    cond = 1'b0;
    it   = '0;
    if (held) begin
      it   = model_q[0];
      fwd1 = pick_source(it.rs1_addr, it.rs1_data);
      fwd2 = pick_source(it.rs2_addr, it.rs2_data);
      hz   = mfw_ena && mfw_is_load && (mfw_addr != '0) &&
             ((it.use_rs1 && mfw_addr == it.rs1_addr) ||
              (it.use_rs2 && mfw_addr == it.rs2_addr));
      a = it.use_rs1 ? fwd1 : it.op1;
      b = it.use_rs2 ? fwd2 : it.op2;
      if (it.is_word) begin
        a[`EX_XLEN-1:32] = '0;
        b[`EX_XLEN-1:32] = '0;
      end
      cond = branch_cond(it.bj_op, a, b);
      // jalr target is rs1 plus imm with bit 0 dropped
      exp_tgt = (it.bj_op == bj_jalr) ? ((fwd1 + it.imm) & ~64'd1) : (it.pc + it.imm);
    end
    exp_mem_valid = held && !hz;
    exp_allowin   = !held || (!hz && mem_allowin);
    check_bit("ex_allowin", ex_allowin, exp_allowin);
    check_bit("mem_valid", mem_valid, exp_mem_valid);
    check_bit("bj_stall", bj_stall, held && (it.bj_op != bj_none) && hz);
    check_bit("bj_taken", bj_taken, held && cond);
    if (held) begin
      check_data("mem_pc", mem_pc, it.pc);
      check_ctrl("mem_ctrl", mem_ctrl, it.ctrl);
      check_data("mem_result", mem_result, model_alu(it.alu_op, a, b, it.is_word));
      check_data("mem_store_data", mem_store_data, fwd2);
      check_data("bj_pc", bj_pc, exp_tgt);
      if (hz) begin
        stall_cnt++;
      end
      if (cond) begin
        taken_cnt++;
      end
    end
  endtask

  // one clock from falling edge to falling edge with the model following the handshake
  task automatic run_cycle(logic allow_new);
    logic accept;
    logic leave;
    drive_inputs(allow_new);
    #1;
    verify_cycle();
    accept = id_valid && exp_allowin;
    leave  = exp_mem_valid && mem_allowin;
    @(posedge clk);
    if (leave) begin
      model_q.delete(0);
    end
    if (accept) begin
      model_q.push_back(cur_item);
      sent++;
    end
    @(negedge clk);
  endtask

  initial begin
    int cycles;
    seed        = 63007;
    sent        = 0;
    stall_cnt   = 0;
    taken_cnt   = 0;
    rst         = 1'b1;
    id_valid    = 1'b0;
    id_pc       = '0;
    id_rs1_addr = '0;
    id_rs2_addr = '0;
    id_rs1_data = '0;
    id_rs2_data = '0;
    id_use_rs1  = 1'b0;
    id_use_rs2  = 1'b0;
    id_op1      = '0;
    id_op2      = '0;
    id_alu_op   = alu_add;
    id_is_word  = 1'b0;
    id_bj_op    = bj_none;
    id_imm      = '0;
    id_ctrl     = '0;
    mfw_ena     = 1'b0;
    mfw_addr    = '0;
    mfw_data    = '0;
    mfw_is_load = 1'b0;
    wfw_ena     = 1'b0;
    wfw_addr    = '0;
    wfw_data    = '0;
    mem_allowin = 1'b0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_bit("mem_valid", mem_valid, 1'b0);
    check_bit("bj_taken", bj_taken, 1'b0);
    check_bit("bj_stall", bj_stall, 1'b0);
    check_bit("ex_allowin", ex_allowin, 1'b1);
    @(negedge clk);

    cycles = 0;
    while (sent < NUM_ITEMS) begin
      run_cycle(1'b1);
      cycles++;
      if (cycles > ITEM_LIMIT) begin
        $display("timeout: stage accepted only %0d of %0d items", sent, NUM_ITEMS);
        abort_run();
      end
    end

    // let the last item leave
    cycles = 0;
    while (model_q.size() != 0) begin
      run_cycle(1'b0);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("timeout: last item never left the stage");
        abort_run();
      end
    end

    $display("items %0d, hazard cycles %0d, taken cycles %0d", sent, stall_cnt, taken_cnt);
    // hazard stalls and taken branches must both have been exercised
    if (stall_cnt == 0 || taken_cnt == 0) begin
      $display("stimulus never produced a load-use stall or a taken branch");
      abort_run();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_forward.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_stage.sv
test/ex_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the execute stage testbench with Verilator and run it
rm -rf obj_dir &&
verilator --binary --timing -f files.f --top-module ex_stage_tb -o ex_stage_sim &&
./obj_dir/ex_stage_sim ||
{ echo "simulation failed"; exit 1; }
